/* hw/pque_cfg.svh */
`ifndef PQUE_CFG_SVH
`define PQUE_CFG_SVH

//////////////////////////////
// data path sizes
//////////////////////////////

`define PQUE_WIDTH    32
`define PQUE_BITMDAT  5

//////////////////////////////
// buffer and queue sizes
//////////////////////////////

`define PQUE_NUMADDR  64
`define PQUE_BITADDR  6

// three queues, so a two bit id can name one that does not exist.
`define PQUE_NUMQ     3
`define PQUE_BITQ     2

// one extra bit so a queue holding every entry still fits.
`define PQUE_BITQCNT  (`PQUE_BITADDR + 1)

`endif

/* hw/pque_pkg.sv */
`include "pque_cfg.svh"

package pque_pkg;

  //////////////////////////////
  // scalar types
  //////////////////////////////

  typedef logic [`PQUE_WIDTH-1:0]   data_t;
  typedef logic [`PQUE_BITADDR-1:0] ptr_t;
  typedef logic [`PQUE_BITQ-1:0]    qid_t;
  typedef logic [`PQUE_BITMDAT-1:0] mdat_t;
  typedef logic [`PQUE_BITQCNT-1:0] cnt_t;

  //////////////////////////////
  // entry and channel words
  //////////////////////////////

  typedef struct packed {
    mdat_t mdat;
    data_t data;
  } entry_t;                              // one word of the entry memory.

  typedef struct packed {
    qid_t  qid;
    ptr_t  ptr;
    mdat_t mdat;
    data_t data;
  } push_cmd_t;

  typedef struct packed {
    cnt_t cnt;                            // count before the push.
  } push_rsp_t;

  typedef struct packed {
    qid_t qid;
  } pop_cmd_t;

  typedef struct packed {
    logic  empty;
    cnt_t  cnt;                           // count before the pop.
    ptr_t  ptr;
    mdat_t mdat;
    data_t data;
  } pop_rsp_t;

endpackage

/* hw/pque_buffer_ram.sv */
`timescale 1ns/1ns
`include "pque_cfg.svh"

module pque_buffer_ram
  import pque_pkg::*;
#(
  parameter int DEPTH = `PQUE_NUMADDR,
  parameter int WIDTH = `PQUE_WIDTH
) (
  input  logic             clk,
  input  logic             wr_en,
  input  ptr_t             wr_addr,
  input  logic [WIDTH-1:0] wr_data,
  input  ptr_t             rd_addr,
  output logic [WIDTH-1:0] rd_data
);

  logic [WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // data appears one cycle after the address.
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

/* hw/pque_queue_table.sv */
`timescale 1ns/1ns
`include "pque_cfg.svh"

module pque_queue_table
  import pque_pkg::*;
(
  input  logic clk,
  input  logic rst,

  input  qid_t rd_qid,
  output ptr_t rd_head,
  output ptr_t rd_tail,
  output cnt_t rd_cnt,

  input  logic wr_en,
  input  qid_t wr_qid,
  input  ptr_t wr_head,
  input  ptr_t wr_tail,
  input  cnt_t wr_cnt
);

  ptr_t head_q [`PQUE_NUMQ];
  ptr_t tail_q [`PQUE_NUMQ];
  cnt_t cnt_q  [`PQUE_NUMQ];

  logic rd_hit;
  logic wr_hit;

  // the id field can encode more queues than exist.
  assign rd_hit = (rd_qid < `PQUE_NUMQ);
  assign wr_hit = (wr_qid < `PQUE_NUMQ);

  //////////////////////////////
  // read port
  //////////////////////////////

  always_comb begin
    rd_head = '0;
    rd_tail = '0;
    rd_cnt  = '0;                         // a missing queue reads as empty.
    if (rd_hit) begin
      rd_head = head_q[rd_qid];
      rd_tail = tail_q[rd_qid];
      rd_cnt  = cnt_q[rd_qid];
    end
  end

  //////////////////////////////
  // write port
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int q = 0; q < `PQUE_NUMQ; q++) begin
        cnt_q[q] <= '0;
      end
    end else if (wr_en && wr_hit) begin
      cnt_q[wr_qid] <= wr_cnt;
    end
  end

  // head and tail mean nothing while the count is zero.
  always_ff @(posedge clk) begin
    if (wr_en && wr_hit) begin
      head_q[wr_qid] <= wr_head;
      tail_q[wr_qid] <= wr_tail;
    end
  end

endmodule

/* hw/pque_engine.sv */
`timescale 1ns/1ns

module pque_engine
  import pque_pkg::*;
(
  input  logic      clk,
  input  logic      rst,

  input  logic      push_req,
  input  push_cmd_t push_cmd,
  output logic      push_ack,
  output push_rsp_t push_rsp,

  input  logic      pop_req,
  input  pop_cmd_t  pop_cmd,
  output logic      pop_ack,
  output pop_rsp_t  pop_rsp,

  output qid_t      tbl_rd_qid,
  input  ptr_t      tbl_head,
  input  ptr_t      tbl_tail,
  input  cnt_t      tbl_cnt,
  output logic      tbl_wr_en,
  output qid_t      tbl_wr_qid,
  output ptr_t      tbl_wr_head,
  output ptr_t      tbl_wr_tail,
  output cnt_t      tbl_wr_cnt,

  output logic      ent_wr_en,
  output ptr_t      ent_wr_addr,
  output entry_t    ent_wr_data,
  output ptr_t      ent_rd_addr,
  input  entry_t    ent_rd_data,

  output logic      lnk_wr_en,
  output ptr_t      lnk_wr_addr,
  output ptr_t      lnk_wr_data,
  output ptr_t      lnk_rd_addr,
  input  ptr_t      lnk_rd_data
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_PUSH_UPD,
    ST_POP_RD,
    ST_POP_CAP,
    ST_ACK_WAIT
  } state_t;

  state_t    state;
  push_cmd_t cmd_q;                       // a pop only fills the qid.
  logic      q_empty;

  assign q_empty    = (tbl_cnt == '0);
  assign tbl_rd_qid = cmd_q.qid;

  //////////////////////////////
  // memory ports
  //////////////////////////////

  assign ent_wr_en   = (state == ST_PUSH_UPD);
  assign ent_wr_addr = cmd_q.ptr;
  assign ent_wr_data = '{mdat: cmd_q.mdat, data: cmd_q.data};
  assign lnk_wr_en   = (state == ST_PUSH_UPD) && !q_empty; // chain behind the old tail.
  assign lnk_wr_addr = tbl_tail;
  assign lnk_wr_data = cmd_q.ptr;

  // the head entry is read every cycle but only used in ST_POP_CAP.
  assign ent_rd_addr = tbl_head;
  assign lnk_rd_addr = tbl_head;

  //////////////////////////////
  // queue table update
  //////////////////////////////

  always_comb begin
    tbl_wr_en   = 1'b0;
    tbl_wr_qid  = cmd_q.qid;
    tbl_wr_head = tbl_head;
    tbl_wr_tail = tbl_tail;
    tbl_wr_cnt  = tbl_cnt;
    if (state == ST_PUSH_UPD) begin
      tbl_wr_en   = 1'b1;
      tbl_wr_tail = cmd_q.ptr;
      tbl_wr_cnt  = tbl_cnt + 1'b1;
      if (q_empty) begin
        tbl_wr_head = cmd_q.ptr;
      end
    end else if (state == ST_POP_CAP) begin
      tbl_wr_en   = 1'b1;
      tbl_wr_head = lnk_rd_data;          // the next entry becomes the head.
      tbl_wr_cnt  = tbl_cnt - 1'b1;
    end
  end

  //////////////////////////////
  // sequencing
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_IDLE;
      push_ack <= 1'b0;
      pop_ack  <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (pop_req) begin              // pop wins, a push keeps waiting.
            state <= ST_POP_RD;
          end else if (push_req) begin
            state <= ST_PUSH_UPD;
          end
        end
        ST_PUSH_UPD: begin
          push_ack <= 1'b1;
          state    <= ST_ACK_WAIT;
        end
        ST_POP_RD: begin
          if (q_empty) begin
            pop_ack <= 1'b1;
            state   <= ST_ACK_WAIT;
          end else begin
            state <= ST_POP_CAP;
          end
        end
        ST_POP_CAP: begin
          pop_ack <= 1'b1;
          state   <= ST_ACK_WAIT;
        end
        ST_ACK_WAIT: begin
          if ((push_ack && !push_req) || (pop_ack && !pop_req)) begin
            push_ack <= 1'b0;
            pop_ack  <= 1'b0;
            state    <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // command capture and responses, held until the next command.
  always_ff @(posedge clk) begin
    if (state == ST_IDLE) begin
      if (pop_req) begin
        cmd_q.qid <= pop_cmd.qid;
      end else if (push_req) begin
        cmd_q <= push_cmd;
      end
    end
    if (state == ST_PUSH_UPD) begin
      push_rsp.cnt <= tbl_cnt;
    end
    if ((state == ST_POP_RD) && q_empty) begin
      pop_rsp <= '{empty: 1'b1, cnt: '0, ptr: '0, mdat: '0, data: '0};
    end
    if (state == ST_POP_CAP) begin
      pop_rsp <= '{empty: 1'b0, cnt: tbl_cnt, ptr: tbl_head,
                   mdat: ent_rd_data.mdat, data: ent_rd_data.data};
    end
  end

endmodule

/* hw/pque_top.sv */
`timescale 1ns/1ns
`include "pque_cfg.svh"

module pque_top
  import pque_pkg::*;
(
  input  logic      clk,
  input  logic      rst,

  input  logic      push_req,
  input  push_cmd_t push_cmd,
  output logic      push_ack,
  output push_rsp_t push_rsp,

  input  logic      pop_req,
  input  pop_cmd_t  pop_cmd,
  output logic      pop_ack,
  output pop_rsp_t  pop_rsp
);

  //////////////////////////////
  // interconnect
  //////////////////////////////

  qid_t   tbl_rd_qid;
  ptr_t   tbl_head;
  ptr_t   tbl_tail;
  cnt_t   tbl_cnt;
  logic   tbl_wr_en;
  qid_t   tbl_wr_qid;
  ptr_t   tbl_wr_head;
  ptr_t   tbl_wr_tail;
  cnt_t   tbl_wr_cnt;

  logic   ent_wr_en;
  ptr_t   ent_wr_addr;
  entry_t ent_wr_data;
  ptr_t   ent_rd_addr;
  entry_t ent_rd_data;

  logic   lnk_wr_en;
  ptr_t   lnk_wr_addr;
  ptr_t   lnk_wr_data;
  ptr_t   lnk_rd_addr;
  ptr_t   lnk_rd_data;

  //////////////////////////////
  // instances
  //////////////////////////////

  pque_engine u_engine (
    .clk         (clk),
    .rst         (rst),
    .push_req    (push_req),
    .push_cmd    (push_cmd),
    .push_ack    (push_ack),
    .push_rsp    (push_rsp),
    .pop_req     (pop_req),
    .pop_cmd     (pop_cmd),
    .pop_ack     (pop_ack),
    .pop_rsp     (pop_rsp),
    .tbl_rd_qid  (tbl_rd_qid),
    .tbl_head    (tbl_head),
    .tbl_tail    (tbl_tail),
    .tbl_cnt     (tbl_cnt),
    .tbl_wr_en   (tbl_wr_en),
    .tbl_wr_qid  (tbl_wr_qid),
    .tbl_wr_head (tbl_wr_head),
    .tbl_wr_tail (tbl_wr_tail),
    .tbl_wr_cnt  (tbl_wr_cnt),
    .ent_wr_en   (ent_wr_en),
    .ent_wr_addr (ent_wr_addr),
    .ent_wr_data (ent_wr_data),
    .ent_rd_addr (ent_rd_addr),
    .ent_rd_data (ent_rd_data),
    .lnk_wr_en   (lnk_wr_en),
    .lnk_wr_addr (lnk_wr_addr),
    .lnk_wr_data (lnk_wr_data),
    .lnk_rd_addr (lnk_rd_addr),
    .lnk_rd_data (lnk_rd_data)
  );

  pque_queue_table u_queue_table (
    .clk     (clk),
    .rst     (rst),
    .rd_qid  (tbl_rd_qid),
    .rd_head (tbl_head),
    .rd_tail (tbl_tail),
    .rd_cnt  (tbl_cnt),
    .wr_en   (tbl_wr_en),
    .wr_qid  (tbl_wr_qid),
    .wr_head (tbl_wr_head),
    .wr_tail (tbl_wr_tail),
    .wr_cnt  (tbl_wr_cnt)
  );

  // metadata and data of each buffered entry.
  pque_buffer_ram #(
    .DEPTH (`PQUE_NUMADDR),
    .WIDTH ($bits(entry_t))
  ) u_entry_ram (
    .clk     (clk),
    .wr_en   (ent_wr_en),
    .wr_addr (ent_wr_addr),
    .wr_data (ent_wr_data),
    .rd_addr (ent_rd_addr),
    .rd_data (ent_rd_data)
  );

  // next pointer of each buffered entry.
  pque_buffer_ram #(
    .DEPTH (`PQUE_NUMADDR),
    .WIDTH ($bits(ptr_t))
  ) u_link_ram (
    .clk     (clk),
    .wr_en   (lnk_wr_en),
    .wr_addr (lnk_wr_addr),
    .wr_data (lnk_wr_data),
    .rd_addr (lnk_rd_addr),
    .rd_data (lnk_rd_data)
  );

endmodule

/* dv/pque_clkgen.sv */
`timescale 1ns/1ns

module pque_clkgen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;                // 10 ns period.
  end

  initial begin
    rst = 1'b1;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

/* dv/pque_properties.sv */
`timescale 1ns/1ns
`include "pque_cfg.svh"

module pque_properties
  import pque_pkg::*;
(
  input logic      clk,
  input logic      rst,
  input logic      push_req,
  input push_cmd_t push_cmd,
  input logic      push_ack,
  input push_rsp_t push_rsp,
  input logic      pop_req,
  input pop_cmd_t  pop_cmd,
  input logic      pop_ack,
  input pop_rsp_t  pop_rsp
);

  //////////////////////////////
  // handshake
  //////////////////////////////

  a_reset_quiet: assert property (@(posedge clk) rst |=> !push_ack && !pop_ack)
    else $error("ack is high during reset");

  a_push_rise: assert property (@(posedge clk) disable iff (rst) $rose(push_ack) |-> push_req)
    else $error("push_ack rose without push_req");
  a_pop_rise: assert property (@(posedge clk) disable iff (rst) $rose(pop_ack) |-> pop_req)
    else $error("pop_ack rose without pop_req");

  a_push_fall: assert property (@(posedge clk) disable iff (rst)
    $fell(push_ack) |-> $past(!push_req))
    else $error("push_ack fell while push_req was high");
  a_pop_fall: assert property (@(posedge clk) disable iff (rst)
    $fell(pop_ack) |-> $past(!pop_req))
    else $error("pop_ack fell while pop_req was high");

  // a response only changes while its ack is low.
  a_push_stable: assert property (@(posedge clk) disable iff (rst)
    push_ack && $past(push_ack) |-> $stable(push_rsp))
    else $error("push_rsp changed while push_ack was high");
  a_pop_stable: assert property (@(posedge clk) disable iff (rst)
    pop_ack && $past(pop_ack) |-> $stable(pop_rsp))
    else $error("pop_rsp changed while pop_ack was high");

  a_one_ack: assert property (@(posedge clk) disable iff (rst) !(push_ack && pop_ack))
    else $error("push_ack and pop_ack are high together");

  //////////////////////////////
  // queue id range
  //////////////////////////////

  a_push_qid: assert property (@(posedge clk) disable iff (rst)
    push_req |-> (push_cmd.qid < `PQUE_NUMQ))
    else $error("push qid out of range");
  a_pop_qid: assert property (@(posedge clk) disable iff (rst)
    pop_req |-> (pop_cmd.qid < `PQUE_NUMQ))
    else $error("pop qid out of range");

endmodule

bind pque_top pque_properties u_properties (
  .clk      (clk),
  .rst      (rst),
  .push_req (push_req),
  .push_cmd (push_cmd),
  .push_ack (push_ack),
  .push_rsp (push_rsp),
  .pop_req  (pop_req),
  .pop_cmd  (pop_cmd),
  .pop_ack  (pop_ack),
  .pop_rsp  (pop_rsp)
);

/* dv/pque_tb.sv */
`timescale 1ns/1ns
`include "pque_cfg.svh"

module pque_tb
  import pque_pkg::*;
();

  localparam int ACK_TIMEOUT = 64;

  logic      clk;
  logic      rst;
  logic      push_req;
  push_cmd_t push_cmd;
  logic      push_ack;
  push_rsp_t push_rsp;
  logic      pop_req;
  pop_cmd_t  pop_cmd;
  logic      pop_ack;
  pop_rsp_t  pop_rsp;

  push_cmd_t model_q [`PQUE_NUMQ][$];     // entries of each queue, head first.
  ptr_t      free_pool [$];
  string     cur_test;
  int        checks;
  int        errors;

  pque_clkgen u_clkgen (.clk(clk), .rst(rst));

  pque_top u_pque_top (
    .clk      (clk),
    .rst      (rst),
    .push_req (push_req),
    .push_cmd (push_cmd),
    .push_ack (push_ack),
    .push_rsp (push_rsp),
    .pop_req  (pop_req),
    .pop_cmd  (pop_cmd),
    .pop_ack  (pop_ack),
    .pop_rsp  (pop_rsp)
  );

  //////////////////////////////
  // checking and model
  //////////////////////////////

  task automatic abort_run(input string what);
    $display("%s did not change within %0d cycles in %s", what, ACK_TIMEOUT, cur_test);
    $display("SOME TESTS FAILED");
    $finish;
  endtask

  task automatic check_val(input string field, input logic [`PQUE_WIDTH-1:0] exp,
                           input logic [`PQUE_WIDTH-1:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERROR %s %s: expected %0h actual %0h", cur_test, field, exp, act);
    end
  endtask

  function automatic push_rsp_t model_push(input push_cmd_t c);
    push_rsp_t exp;
    exp.cnt = cnt_t'(model_q[c.qid].size());
    model_q[c.qid].push_back(c);
    for (int i = 0; i < free_pool.size(); i++) begin
      if (free_pool[i] == c.ptr) begin
        free_pool.delete(i);
        break;
      end
    end
    return exp;
  endfunction

  function automatic pop_rsp_t model_pop(input qid_t q);
    pop_rsp_t exp;
    exp = '0;
    if (model_q[q].size() == 0) begin
      exp.empty = 1'b1;
    end else begin
      exp.cnt  = cnt_t'(model_q[q].size());
      exp.ptr  = model_q[q][0].ptr;
      exp.mdat = model_q[q][0].mdat;
      exp.data = model_q[q][0].data;
      free_pool.push_back(exp.ptr);       // the pointer may be queued again.
      void'(model_q[q].pop_front());
    end
    return exp;
  endfunction

  //////////////////////////////
  // channel handshakes
  //////////////////////////////

  task automatic wait_ack(input bit is_pop, input logic level);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (((is_pop ? pop_ack : push_ack) !== level) && (n < ACK_TIMEOUT));
    if ((is_pop ? pop_ack : push_ack) !== level) begin
      abort_run(is_pop ? "pop_ack" : "push_ack");
    end
  endtask

  task automatic push_xfer(input push_cmd_t cmd, output push_rsp_t rsp);
    push_req <= 1'b1;
    push_cmd <= cmd;
    wait_ack(1'b0, 1'b1);
    rsp = push_rsp;
    @(posedge clk);                       // req stays up one more cycle.
    if (push_ack !== 1'b1) begin
      errors++;
      $display("push_ack dropped while push_req was still high in %s", cur_test);
    end
    push_req <= 1'b0;
    wait_ack(1'b0, 1'b0);
  endtask

  task automatic pop_xfer(input qid_t q, output pop_rsp_t rsp);
    pop_req <= 1'b1;
    pop_cmd <= '{qid: q};
    wait_ack(1'b1, 1'b1);
    rsp = pop_rsp;
    @(posedge clk);
    if (pop_ack !== 1'b1) begin
      errors++;
      $display("pop_ack dropped while pop_req was still high in %s", cur_test);
    end
    pop_req <= 1'b0;
    wait_ack(1'b1, 1'b0);
  endtask

  task automatic check_pop(input pop_rsp_t exp, input pop_rsp_t act);
    check_val("pop empty", exp.empty, act.empty);
    check_val("pop cnt", exp.cnt, act.cnt);
    if (!exp.empty) begin
      check_val("pop ptr", exp.ptr, act.ptr);
      check_val("pop mdat", exp.mdat, act.mdat);
      check_val("pop data", exp.data, act.data);
    end
  endtask

  task automatic push_entry(input qid_t q, input ptr_t p, input mdat_t m, input data_t d);
    push_cmd_t cmd;
    push_rsp_t exp;
    push_rsp_t act;
    cmd = '{qid: q, ptr: p, mdat: m, data: d};
    exp = model_push(cmd);
    push_xfer(cmd, act);
    check_val("push cnt", exp.cnt, act.cnt);
  endtask

  task automatic push_random(input qid_t q);
    ptr_t p;
    p = free_pool[$urandom_range(free_pool.size() - 1)];
    push_entry(q, p, mdat_t'($urandom), $urandom);
  endtask

  task automatic pop_entry(input qid_t q, output ptr_t p);
    pop_rsp_t exp;
    pop_rsp_t act;
    exp = model_pop(q);
    pop_xfer(q, act);
    check_pop(exp, act);
    p = exp.ptr;
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  task automatic test_reset_empty();
    ptr_t p;
    cur_test = "test_reset_empty";
    check_val("push_ack", 1'b0, push_ack);
    check_val("pop_ack", 1'b0, pop_ack);
    for (int q = 0; q < `PQUE_NUMQ; q++) begin
      pop_entry(qid_t'(q), p);
    end
  endtask

  task automatic test_fifo_order();
    ptr_t p;
    cur_test = "test_fifo_order";
    repeat (8) push_random(qid_t'(0));
    repeat (9) pop_entry(qid_t'(0), p);   // the last one finds the queue empty.
  endtask

  task automatic test_queue_isolation();
    ptr_t p;
    cur_test = "test_queue_isolation";
    for (int i = 0; i < 6; i++) begin
      for (int q = 0; q < `PQUE_NUMQ; q++) begin
        push_random(qid_t'(q));
      end
    end
    for (int q = 0; q < `PQUE_NUMQ; q++) begin
      repeat (7) pop_entry(qid_t'(q), p);
    end
  endtask

  task automatic test_pointer_reuse();
    ptr_t freed [4];
    ptr_t p;
    cur_test = "test_pointer_reuse";
    repeat (6) push_random(qid_t'(1));
    for (int i = 0; i < 4; i++) begin
      pop_entry(qid_t'(1), freed[i]);
    end
    // queue 2 gets the freed pointers in reverse, so every link is rewritten.
    for (int i = 0; i < 4; i++) begin
      push_entry(qid_t'(2), freed[3 - i], mdat_t'(i), 32'ha000_0000 + i);
    end
    repeat (2) push_random(qid_t'(1));
    repeat (5) pop_entry(qid_t'(2), p);
    repeat (5) pop_entry(qid_t'(1), p);
  endtask

  task automatic test_contention();
    push_cmd_t cmd;
    push_rsp_t push_exp;
    push_rsp_t push_act;
    pop_rsp_t  pop_exp;
    pop_rsp_t  pop_act;
    ptr_t      p;
    cur_test = "test_contention";
    repeat (2) push_random(qid_t'(0));
    cmd = '{qid: qid_t'(0), ptr: free_pool[$urandom_range(free_pool.size() - 1)],
            mdat: mdat_t'($urandom), data: $urandom};
    pop_exp  = model_pop(qid_t'(0));      // pop is served before the push.
    push_exp = model_push(cmd);
    fork
      push_xfer(cmd, push_act);
      pop_xfer(qid_t'(0), pop_act);
    join
    check_pop(pop_exp, pop_act);
    check_val("push cnt", push_exp.cnt, push_act.cnt);
    repeat (3) pop_entry(qid_t'(0), p);
  endtask

  task automatic test_random_mix();
    qid_t q;
    ptr_t p;
    cur_test = "test_random_mix";
    for (int i = 0; i < 200; i++) begin
      q = qid_t'($urandom_range(`PQUE_NUMQ - 1));
      if (($urandom_range(1) == 1) && (free_pool.size() > 0)) begin
        push_random(q);
      end else begin
        pop_entry(q, p);
      end
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    int n;
    void'($urandom(32'h44c7fd11));
    push_req <= 1'b0;
    push_cmd <= '0;
    pop_req  <= 1'b0;
    pop_cmd  <= '0;
    checks   = 0;
    errors   = 0;
    cur_test = "reset";
    for (int i = 0; i < `PQUE_NUMADDR; i++) begin
      free_pool.push_back(ptr_t'(i));
    end
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while ((rst !== 1'b0) && (n < ACK_TIMEOUT));
    if (rst !== 1'b0) begin
      abort_run("rst");
    end
    test_reset_empty();
    test_fifo_order();
    test_queue_isolation();
    test_pointer_reuse();
    test_contention();
    test_random_mix();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+hw
hw/pque_pkg.sv
hw/pque_buffer_ram.sv
hw/pque_queue_table.sv
hw/pque_engine.sv
hw/pque_top.sv
dv/pque_clkgen.sv
dv/pque_properties.sv
dv/pque_tb.sv

/* Bender.yml */
package:
  name: pque

export_include_dirs:
  - hw

sources:
  - hw/pque_pkg.sv
  - hw/pque_buffer_ram.sv
  - hw/pque_queue_table.sv
  - hw/pque_engine.sv
  - hw/pque_top.sv
  - target: test
    files:
      - dv/pque_clkgen.sv
      - dv/pque_properties.sv
      - dv/pque_tb.sv
